// ==== rtl/rp_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared types and constants of the analog signal path and system bus
// referenced by scoped name from every block, no import
////////////////////////////////////////////////////////////////////////////

package rp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and bus map
  ////////////////////////////////////////////////////////////////////////////

  localparam int SAMPLE_W   = 14;                  // converter resolution
  localparam int RAW_ADC_W  = 16;                  // adc pins, lowest 2 bits reserved
  localparam int SLOT_COUNT = 8;                   // bus regions
  localparam int SLOT_W     = $clog2(SLOT_COUNT);  // slot number field width
  localparam int SLOT_LSB   = 20;                  // slot number in addr[22:20]

  // plain vectors with a meaning
  typedef logic signed [SAMPLE_W-1:0] sample_t;    // two's complement sample
  typedef logic        [SAMPLE_W-1:0] code_t;      // offset code, negative slope
  typedef logic signed [SAMPLE_W:0]   sum_t;       // one guard bit before saturation
  typedef logic        [31:0]         word_t;      // bus address / data
  typedef logic        [7:0]          led_t;
  typedef logic        [SLOT_COUNT-1:0] slot_t;    // one-hot slot select

  // housekeeping map, byte offsets inside slot 0
  localparam word_t HK_ID       = 32'ha17c_0001;
  localparam word_t HK_ID_OFS   = 32'h0000_0000;
  localparam word_t HK_LOOP_OFS = 32'h0000_0004;
  localparam word_t HK_LED_OFS  = 32'h0000_0030;

  // converter code of sample zero, msb low and the rest high
  localparam code_t CODE_ZERO = {1'b0, {(SAMPLE_W-1){1'b1}}};

  ////////////////////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    sample_t a;  // channel 1
    sample_t b;  // channel 2
  } sample_pair_t;

  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    logic [3:0] sel;    // write byte enables
    logic       wen;    // single cycle strobe
    logic       ren;    // single cycle strobe
  } sys_req_t;

  typedef struct packed {
    word_t rdata;
    logic  err;
    logic  ack;  // response valid
  } sys_rsp_t;

endpackage

// ==== rtl/sys_bus_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// system bus split into eight address slots, slot 0 is housekeeping
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sys_bus_decoder (
  input  rp_pkg::sys_req_t req_i,     // from bus master
  output rp_pkg::sys_rsp_t rsp_o,     // back to bus master
  output rp_pkg::sys_req_t hk_req_o,  // slot 0 request
  input  rp_pkg::sys_rsp_t hk_rsp_i   // slot 0 response
);

  logic [rp_pkg::SLOT_W-1:0] slot_idx;
  rp_pkg::slot_t             slot_cs;    // one-hot
  rp_pkg::slot_t             slot_err;
  rp_pkg::slot_t             slot_ack;
  rp_pkg::sys_rsp_t          slot_rsp [rp_pkg::SLOT_COUNT];

  assign slot_idx = req_i.addr[rp_pkg::SLOT_LSB +: rp_pkg::SLOT_W];
  assign slot_cs  = rp_pkg::slot_t'(1) << slot_idx;

  // strobes only reach the addressed slot
  always_comb begin
    hk_req_o     = req_i;
    hk_req_o.wen = req_i.wen & slot_cs[0];
    hk_req_o.ren = req_i.ren & slot_cs[0];
  end

  ////////////////////////////////////////////////////////////////////////////
  // slot responses
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    slot_rsp[0] = hk_rsp_i;
    // empty slots: instant ack, zero data, no error
    for (int i = 1; i < rp_pkg::SLOT_COUNT; i++) begin
      slot_rsp[i] = '{rdata: '0, err: 1'b0, ack: 1'b1};
    end
  end

  always_comb begin
    for (int i = 0; i < rp_pkg::SLOT_COUNT; i++) begin
      slot_err[i] = slot_rsp[i].err;
      slot_ack[i] = slot_rsp[i].ack;
    end
  end

  // merge, only the selected slot counts
  always_comb begin
    rsp_o.rdata = slot_rsp[slot_idx].rdata;
    rsp_o.err   = |(slot_cs & slot_err);
    rsp_o.ack   = |(slot_cs & slot_ack);
  end

endmodule

// ==== rtl/adc_frontend.sv ====
////////////////////////////////////////////////////////////////////////////
// adc input register, offset code to two's complement, loopback select
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module adc_frontend (
  input  logic                         adc_clk,
  input  logic                         rst_n_i,
  input  logic [rp_pkg::RAW_ADC_W-1:0] adc_dat_a_i,  // raw pins, [1:0] reserved
  input  logic [rp_pkg::RAW_ADC_W-1:0] adc_dat_b_i,
  input  logic                         loop_i,       // digital loopback on
  input  rp_pkg::sample_pair_t         dac_loop_i,   // saturated dac samples
  output rp_pkg::sample_pair_t         adc_o
);

  rp_pkg::code_t        raw_a_q;  // io register, ch 1
  rp_pkg::code_t        raw_b_q;  // io register, ch 2
  rp_pkg::sample_pair_t conv;

  // keep the upper 14 bits
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      raw_a_q <= rp_pkg::CODE_ZERO;  // reads back as sample 0
      raw_b_q <= rp_pkg::CODE_ZERO;
    end else begin
      raw_a_q <= adc_dat_a_i[rp_pkg::RAW_ADC_W-1 -: rp_pkg::SAMPLE_W];
      raw_b_q <= adc_dat_b_i[rp_pkg::RAW_ADC_W-1 -: rp_pkg::SAMPLE_W];
    end
  end

  // negative slope: sign kept, magnitude bits flipped
  always_comb begin
    conv.a = {raw_a_q[rp_pkg::SAMPLE_W-1], ~raw_a_q[rp_pkg::SAMPLE_W-2:0]};
    conv.b = {raw_b_q[rp_pkg::SAMPLE_W-1], ~raw_b_q[rp_pkg::SAMPLE_W-2:0]};
  end

  assign adc_o = loop_i ? dac_loop_i : conv;  // loopback bypasses the register

endmodule

// ==== rtl/dac_backend.sv ====
////////////////////////////////////////////////////////////////////////////
// generator plus controller sum, 14 bit saturation, dac code register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module dac_backend (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  rp_pkg::sample_pair_t asg_i,         // generator samples
  input  rp_pkg::sample_pair_t pid_i,         // controller samples
  output rp_pkg::sample_pair_t dac_sum_o,     // saturated, before the register
  output rp_pkg::code_t        dac_code_a_o,  // to dac pins, ch 1
  output rp_pkg::code_t        dac_code_b_o   // ch 2
);

  rp_pkg::sum_t         sum_a;
  rp_pkg::sum_t         sum_b;
  rp_pkg::sample_pair_t sat_pair;

  // clamp when the guard bit disagrees with the sign
  function automatic rp_pkg::sample_t saturate(input rp_pkg::sum_t s);
    logic ovf;
    ovf = s[rp_pkg::SAMPLE_W] ^ s[rp_pkg::SAMPLE_W-1];
    if (ovf) begin
      return {s[rp_pkg::SAMPLE_W], {(rp_pkg::SAMPLE_W-1){~s[rp_pkg::SAMPLE_W]}}};
    end
    return s[rp_pkg::SAMPLE_W-1:0];
  endfunction

  // signed to offset code, negative slope
  function automatic rp_pkg::code_t to_code(input rp_pkg::sample_t s);
    return {s[rp_pkg::SAMPLE_W-1], ~s[rp_pkg::SAMPLE_W-2:0]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // sum and saturation
  ////////////////////////////////////////////////////////////////////////////

  // sign extended into 15 bits, cannot overflow
  assign sum_a = rp_pkg::sum_t'(asg_i.a) + rp_pkg::sum_t'(pid_i.a);
  assign sum_b = rp_pkg::sum_t'(asg_i.b) + rp_pkg::sum_t'(pid_i.b);

  always_comb begin
    sat_pair.a = saturate(sum_a);
    sat_pair.b = saturate(sum_b);
  end

  assign dac_sum_o = sat_pair;  // also feeds the loopback

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dac_code_a_o <= rp_pkg::CODE_ZERO;  // mid scale
      dac_code_b_o <= rp_pkg::CODE_ZERO;
    end else begin
      dac_code_a_o <= to_code(sat_pair.a);
      dac_code_b_o <= to_code(sat_pair.b);
    end
  end

endmodule

// ==== rtl/housekeeping_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// slot 0 registers: id word, loopback switch, led register and led select
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module housekeeping_regs (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::sys_req_t req_i,        // strobes already gated to slot 0
  output rp_pkg::sys_rsp_t rsp_o,        // ack one cycle after strobe
  output logic             loop_o,       // digital loopback switch
  input  logic             ps_led_en_i,  // processor takes the leds
  input  rp_pkg::led_t     ps_led_i,
  output rp_pkg::led_t     led_o
);

  rp_pkg::word_t ofs;       // byte offset inside the slot
  logic          hit_id;
  logic          hit_loop;
  logic          hit_led;
  logic          access;    // any strobe this cycle
  rp_pkg::word_t rd_mux;
  logic          loop_q;
  rp_pkg::led_t  led_q;
  rp_pkg::word_t rdata_q;
  logic          err_q;
  logic          ack_q;

  assign ofs      = rp_pkg::word_t'(req_i.addr[rp_pkg::SLOT_LSB-1:0]);
  assign hit_id   = (ofs == rp_pkg::HK_ID_OFS);
  assign hit_loop = (ofs == rp_pkg::HK_LOOP_OFS);
  assign hit_led  = (ofs == rp_pkg::HK_LED_OFS);
  assign access   = req_i.wen | req_i.ren;

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  // both registers live in byte lane 0
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      loop_q <= 1'b0;
      led_q  <= '0;
    end else if (req_i.wen && req_i.sel[0]) begin
      if (hit_loop) loop_q <= req_i.wdata[0];
      if (hit_led)  led_q  <= req_i.wdata[7:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side and response
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_mux = '0;  // writes and bad offsets return zero
    if (req_i.ren) begin
      if (hit_id)        rd_mux = rp_pkg::HK_ID;
      else if (hit_loop) rd_mux = rp_pkg::word_t'(loop_q);
      else if (hit_led)  rd_mux = rp_pkg::word_t'(led_q);
    end
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= access;
      err_q <= access & ~(hit_id | hit_loop | hit_led);  // unmapped offset
    end
  end

  always_ff @(posedge adc_clk) begin
    if (access) rdata_q <= rd_mux;
  end

  assign rsp_o  = '{rdata: rdata_q, err: err_q, ack: ack_q};
  assign loop_o = loop_q;

  // processor pattern wins over the register
  assign led_o = ps_led_en_i ? ps_led_i : led_q;

endmodule

// ==== rtl/analog_top.sv ====
////////////////////////////////////////////////////////////////////////////
// top level: adc and dac paths, loopback and housekeeping on one clock
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module analog_top (
  input  logic                         adc_clk,
  input  logic                         rst_n_i,
  // adc
  input  logic [rp_pkg::RAW_ADC_W-1:0] adc_dat_a_i,
  input  logic [rp_pkg::RAW_ADC_W-1:0] adc_dat_b_i,
  // sample sources for the dac
  input  rp_pkg::sample_pair_t         asg_i,
  input  rp_pkg::sample_pair_t         pid_i,
  // converted adc samples
  output rp_pkg::sample_pair_t         adc_o,
  // dac
  output rp_pkg::code_t                dac_code_a_o,
  output rp_pkg::code_t                dac_code_b_o,
  // system bus
  input  rp_pkg::sys_req_t             sys_req_i,
  output rp_pkg::sys_rsp_t             sys_rsp_o,
  // leds
  input  logic                         ps_led_en_i,
  input  rp_pkg::led_t                 ps_led_i,
  output rp_pkg::led_t                 led_o
);

  rp_pkg::sys_req_t     hk_req;
  rp_pkg::sys_rsp_t     hk_rsp;
  logic                 digital_loop;
  rp_pkg::sample_pair_t dac_sum;  // saturated, unregistered

  ////////////////////////////////////////////////////////////////////////////
  // bus
  ////////////////////////////////////////////////////////////////////////////

  sys_bus_decoder i_bus (
    .req_i    (sys_req_i),
    .rsp_o    (sys_rsp_o),
    .hk_req_o (hk_req),
    .hk_rsp_i (hk_rsp)
  );

  housekeeping_regs i_hk (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .req_i       (hk_req),
    .rsp_o       (hk_rsp),
    .loop_o      (digital_loop),
    .ps_led_en_i (ps_led_en_i),
    .ps_led_i    (ps_led_i),
    .led_o       (led_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // signal path
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_i      (digital_loop),
    .dac_loop_i  (dac_sum),
    .adc_o       (adc_o)
  );

  dac_backend i_dac (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .asg_i        (asg_i),
    .pid_i        (pid_i),
    .dac_sum_o    (dac_sum),
    .dac_code_a_o (dac_code_a_o),
    .dac_code_b_o (dac_code_b_o)
  );

endmodule

// ==== include/tb_checks.svh ====
////////////////////////////////////////////////////////////////////////////
// testbench compare tasks and model conversions, included in the tb top
////////////////////////////////////////////////////////////////////////////

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// common failure exit
task automatic report_fail(input string name, input string exp_s, input string act_s);
  $display("[FAIL] %s: expected %s, actual %s", name, exp_s, act_s);
  $display("Regression failed");
  $fatal(1, "%s", name);
endtask

task automatic check_code(input string name, input rp_pkg::code_t exp, input rp_pkg::code_t act);
  if (act !== exp) report_fail(name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_sample(input string name, input rp_pkg::sample_t exp,
                            input rp_pkg::sample_t act);
  if (act !== exp) report_fail(name, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

task automatic check_word(input string name, input rp_pkg::word_t exp, input rp_pkg::word_t act);
  if (act !== exp) report_fail(name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_led(input string name, input rp_pkg::led_t exp, input rp_pkg::led_t act);
  if (act !== exp) report_fail(name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) report_fail(name, $sformatf("%b", exp), $sformatf("%b", act));
endtask

// model: raw pins to sample, upper 14 bits with all but the sign inverted
function automatic rp_pkg::sample_t raw_to_sample(input logic [rp_pkg::RAW_ADC_W-1:0] raw);
  logic [rp_pkg::SAMPLE_W-1:0] flip;  // magnitude bits only
  flip = {1'b0, {(rp_pkg::SAMPLE_W-1){1'b1}}};
  return raw[rp_pkg::RAW_ADC_W-1 -: rp_pkg::SAMPLE_W] ^ flip;
endfunction

// model: integer sum clamped to the signed range
function automatic rp_pkg::sample_t sat_sum(input rp_pkg::sample_t x, input rp_pkg::sample_t y);
  int s;
  int lim;
  lim = 1 << (rp_pkg::SAMPLE_W - 1);
  s   = int'(x) + int'(y);
  if (s > lim - 1) s = lim - 1;
  if (s < -lim)    s = -lim;
  return rp_pkg::sample_t'(s);
endfunction

// model: sample to dac code, sign kept and the rest inverted
function automatic rp_pkg::code_t sample_to_code(input rp_pkg::sample_t s);
  logic [rp_pkg::SAMPLE_W-1:0] flip;
  flip = {1'b0, {(rp_pkg::SAMPLE_W-1){1'b1}}};
  return s ^ flip;
endfunction

`endif

// ==== test/tb_analog_top.sv ====
////////////////////////////////////////////////////////////////////////////
// directed testbench of the analog top: adc, dac, loopback, bus map, leds
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_analog_top;

  localparam int T_CLK       = 100;                        // ns
  localparam int RST_CYCLES  = 5;
  localparam int N_RAND      = 32;                         // random vectors per test
  localparam int TEST_CYCLES = RST_CYCLES + 8 * N_RAND + 120;  // all tests summed
  localparam int MARGIN      = 100;
  localparam rp_pkg::word_t   SLOT5_ADDR = 32'h0050_0000;
  localparam rp_pkg::word_t   BAD_OFS    = 32'h0000_0008;  // unmapped in slot 0
  localparam rp_pkg::sample_t S_MAX      = 14'h1fff;
  localparam rp_pkg::sample_t S_MIN      = 14'h2000;

  logic                         adc_clk;
  logic                         rst_n;
  logic [rp_pkg::RAW_ADC_W-1:0] adc_dat_a;
  logic [rp_pkg::RAW_ADC_W-1:0] adc_dat_b;
  rp_pkg::sample_pair_t         asg;
  rp_pkg::sample_pair_t         pid;
  rp_pkg::sample_pair_t         adc;
  rp_pkg::code_t                dac_code_a;
  rp_pkg::code_t                dac_code_b;
  rp_pkg::sys_req_t             sys_req;
  rp_pkg::sys_rsp_t             sys_rsp;
  logic                         ps_led_en;
  rp_pkg::led_t                 ps_led;
  rp_pkg::led_t                 led;
  rp_pkg::led_t                 led_reg;  // expected led register

  `include "tb_checks.svh"

  analog_top DUT (
    .adc_clk (adc_clk), .rst_n_i (rst_n),
    .adc_dat_a_i (adc_dat_a), .adc_dat_b_i (adc_dat_b),
    .asg_i (asg), .pid_i (pid), .adc_o (adc),
    .dac_code_a_o (dac_code_a), .dac_code_b_o (dac_code_b),
    .sys_req_i (sys_req), .sys_rsp_o (sys_rsp),
    .ps_led_en_i (ps_led_en), .ps_led_i (ps_led), .led_o (led)
  );

  always #(T_CLK/2) adc_clk = ~adc_clk;

  initial begin
    #((TEST_CYCLES + MARGIN) * T_CLK);
    $display("watchdog expired, the tests did not finish in time");
    $display("Regression failed");
    $fatal(1, "watchdog");
  end

  function automatic rp_pkg::sample_pair_t rand_pair();
    logic [31:0] r;
    r = $urandom;
    return r[2*rp_pkg::SAMPLE_W-1:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bus access, strobe for one cycle then wait for ack
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_access(input rp_pkg::word_t addr, input rp_pkg::word_t wdata,
                            input logic [3:0] sel, input logic wr,
                            output rp_pkg::sys_rsp_t rsp);
    int waited;
    waited = 0;
    @(negedge adc_clk);
    sys_req = '{addr: addr, wdata: wdata, sel: sel, wen: wr, ren: ~wr};
    #(T_CLK/4);                                // empty slots ack right away
    while (!sys_rsp.ack) begin
      @(negedge adc_clk);
      sys_req.wen = 1'b0;
      sys_req.ren = 1'b0;
      waited++;
      if (waited > 4) begin
        $display("bus access to %h got no acknowledge within 4 cycles", addr);
        $display("Regression failed");
        $fatal(1, "bus timeout");
      end
      #(T_CLK/4);
    end
    rsp = sys_rsp;
    @(negedge adc_clk);
    sys_req.wen = 1'b0;
    sys_req.ren = 1'b0;
  endtask

  task automatic dac_vector(input rp_pkg::sample_pair_t g, input rp_pkg::sample_pair_t c);
    @(negedge adc_clk);
    asg = g;
    pid = c;
    @(negedge adc_clk);                        // one register stage
    check_code("dac sum a", sample_to_code(sat_sum(g.a, c.a)), dac_code_a);
    check_code("dac sum b", sample_to_code(sat_sum(g.b, c.b)), dac_code_b);
  endtask

  task automatic adc_vector(input string name);
    logic [31:0] r;
    @(negedge adc_clk);
    r = $urandom;
    adc_dat_a = r[rp_pkg::RAW_ADC_W-1:0];      // reserved bits random too
    adc_dat_b = r[31 -: rp_pkg::RAW_ADC_W];
    @(negedge adc_clk);
    check_sample(name, raw_to_sample(adc_dat_a), adc.a);
    check_sample(name, raw_to_sample(adc_dat_b), adc.b);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    rp_pkg::sys_rsp_t rsp;
    check_code("reset dac a", sample_to_code('0), dac_code_a);
    check_code("reset dac b", sample_to_code('0), dac_code_b);
    check_led("reset led", 8'h00, led);
    bus_access(rp_pkg::HK_LOOP_OFS, '0, 4'h0, 1'b0, rsp);
    check_word("reset loop read", 32'h0, rsp.rdata);
    check_bit("reset loop err", 1'b0, rsp.err);
  endtask

  task automatic test_adc_conv();
    for (int i = 0; i < N_RAND; i++) adc_vector("adc conversion");
  endtask

  task automatic test_dac_sum();
    dac_vector('{S_MAX, S_MIN}, '{S_MAX, S_MIN});  // both clamp
    dac_vector('{S_MAX, S_MIN}, '{S_MIN, S_MAX});  // lands on -1
    dac_vector('{14'sd1, -14'sd1}, '{S_MAX, S_MIN});
    dac_vector('{14'sd0, 14'sd0}, '{14'sd0, 14'sd0});
    for (int i = 0; i < N_RAND; i++) dac_vector(rand_pair(), rand_pair());
  endtask

  task automatic test_loopback();
    rp_pkg::sys_rsp_t rsp;
    rp_pkg::sample_pair_t g;
    rp_pkg::sample_pair_t c;
    bus_access(rp_pkg::HK_LOOP_OFS, 32'h1, 4'h1, 1'b1, rsp);
    bus_access(rp_pkg::HK_LOOP_OFS, '0, 4'h0, 1'b0, rsp);
    check_word("loop readback", 32'h1, rsp.rdata);
    for (int i = 0; i < N_RAND / 4; i++) begin
      @(negedge adc_clk);
      g   = rand_pair();
      c   = rand_pair();
      asg = g;
      pid = c;
      #(T_CLK/4);                              // combinational path
      check_sample("loopback a", sat_sum(g.a, c.a), adc.a);
      check_sample("loopback b", sat_sum(g.b, c.b), adc.b);
    end
    bus_access(rp_pkg::HK_LOOP_OFS, 32'h0, 4'h1, 1'b1, rsp);
    adc_vector("loopback off");
  endtask

  task automatic test_bus_map();
    rp_pkg::sys_rsp_t rsp;
    bus_access(rp_pkg::HK_ID_OFS, '0, 4'h0, 1'b0, rsp);
    check_word("id read", rp_pkg::HK_ID, rsp.rdata);
    check_bit("id err", 1'b0, rsp.err);
    // empty slot answers in the strobe cycle, slot 0 still holds the id word
    @(negedge adc_clk);
    sys_req = '{addr: SLOT5_ADDR, wdata: '0, sel: 4'h0, wen: 1'b0, ren: 1'b1};
    #(T_CLK/4);
    check_bit("slot 5 ack", 1'b1, sys_rsp.ack);
    check_word("slot 5 data", 32'h0, sys_rsp.rdata);
    check_bit("slot 5 err", 1'b0, sys_rsp.err);
    @(negedge adc_clk);
    sys_req.ren = 1'b0;
    bus_access(BAD_OFS, '0, 4'h0, 1'b0, rsp);
    check_bit("unmapped err", 1'b1, rsp.err);
    check_word("unmapped data", 32'h0, rsp.rdata);
    // led register sits in lane 0 only
    bus_access(rp_pkg::HK_LED_OFS, 32'h0000_00a5, 4'h1, 1'b1, rsp);
    led_reg = 8'ha5;
    bus_access(rp_pkg::HK_LED_OFS, 32'hffff_ff3c, 4'he, 1'b1, rsp);  // lane 0 masked
    bus_access(rp_pkg::HK_LED_OFS, '0, 4'h0, 1'b0, rsp);
    check_word("led masked lanes", {24'h0, led_reg}, rsp.rdata);
    bus_access(rp_pkg::HK_LED_OFS, 32'h1234_5642, 4'h1, 1'b1, rsp);
    led_reg = 8'h42;
    bus_access(rp_pkg::HK_LED_OFS, '0, 4'h0, 1'b0, rsp);
    check_word("led lane 0", {24'h0, led_reg}, rsp.rdata);
    check_led("led register out", led_reg, led);
  endtask

  task automatic test_led_override();
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      @(negedge adc_clk);
      r         = $urandom;
      ps_led_en = 1'b1;
      ps_led    = r[7:0];
      #(T_CLK/4);
      check_led("led override", r[7:0], led);
    end
    @(negedge adc_clk);
    ps_led_en = 1'b0;
    #(T_CLK/4);
    check_led("led register", led_reg, led);
  endtask

  initial begin
    void'($urandom(32'hf8f7_1d3e));
    adc_clk   = 1'b0;
    rst_n     = 1'b0;
    adc_dat_a = '0;
    adc_dat_b = '0;
    asg       = '0;
    pid       = '0;
    sys_req   = '0;
    ps_led_en = 1'b0;
    ps_led    = '0;
    led_reg   = '0;
    repeat (RST_CYCLES) @(posedge adc_clk);
    @(negedge adc_clk);
    rst_n = 1'b1;
    test_reset();
    test_adc_conv();
    test_dac_sum();
    test_loopback();
    test_bus_map();
    test_led_override();
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
rtl/rp_pkg.sv
rtl/sys_bus_decoder.sv
rtl/adc_frontend.sv
rtl/dac_backend.sv
rtl/housekeeping_regs.sv
rtl/analog_top.sv
test/tb_analog_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, decide from the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_analog_top \
  -Mdir obj_dir -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1
grep -q "^Regression passed$" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
